/* secded_codec_top.f */
secded_pkg.sv
secded_hamming_gen.sv
secded_syndrome_calc.sv
secded_corrector.sv
secded_codec_top.sv
tb_secded_codec.sv

/* Makefile */
SRCS = secded_pkg.sv secded_hamming_gen.sv secded_syndrome_calc.sv \
       secded_corrector.sv secded_codec_top.sv tb_secded_codec.sv

.PHONY: all run clean

all: run

obj_dir/Vtb_secded_codec: $(SRCS) secded_codec_top.f
	verilator --binary --timing --assert -f secded_codec_top.f \
		--top-module tb_secded_codec

run: obj_dir/Vtb_secded_codec
	./obj_dir/Vtb_secded_codec > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_secded_codec.sv */
// secded codec testbench: table driven encoder and decoder checks against a reference model.
`timescale 1ns/10ps

module tb_secded_codec;

    localparam int clk_period  = 100;
    localparam int no_flip     = -1;
    localparam int num_walk    = secded_pkg::data_width;
    localparam int num_single  = secded_pkg::code_width;
    localparam int num_double  = 24;
    localparam int num_mixed   = 48;
    localparam int num_entries = 2 + num_walk + num_single + num_double + num_mixed;

    typedef struct packed {
        secded_pkg::code_t  code;
        secded_pkg::data_t  data;
        logic               single_err;
        logic               double_err;
    } expect_t;

    logic               clk;
    logic               rst_n;
    secded_pkg::data_t  data_in;
    secded_pkg::code_t  code_out;
    secded_pkg::code_t  code_in;
    secded_pkg::data_t  data_out;
    logic               single_err;
    logic               double_err;

    // stimulus table, flip positions are code word bit indices.
    string              tbl_name  [num_entries];
    secded_pkg::data_t  tbl_data  [num_entries];
    int                 tbl_flip1 [num_entries];
    int                 tbl_flip2 [num_entries];

    expect_t  exp_q[$];
    int       idx_q[$];
    int       seed   = 32'ha48168d8;
    int       checks = 0;
    int       errors = 0;

    secded_codec_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_in    (data_in),
        .code_out   (code_out),
        .code_in    (code_in),
        .data_out   (data_out),
        .single_err (single_err),
        .double_err (double_err)
    );

    always #(clk_period / 2) clk = ~clk;

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    // hamming checks are the xor of the positions of all set data bits.
    function automatic secded_pkg::code_t encode_word(input secded_pkg::data_t data);
        secded_pkg::syndrome_t  ham;
        secded_pkg::data_t      d;
        logic                   overall;
        ham = '0;
        d   = data;
        for (int i = 0; i < secded_pkg::data_width; i++) begin
            if (d[0]) begin
                ham = ham ^ secded_pkg::data_pos(i);
            end
            d = d >> 1;
        end
        overall = (^data) ^ (^ham);
        return {overall, ham, data};
    endfunction

    function automatic secded_pkg::code_t flip_bits(input secded_pkg::code_t code,
                                                    input int f1, input int f2);
        secded_pkg::code_t rx;
        rx = code;
        if (f1 != no_flip) begin
            rx = rx ^ (secded_pkg::code_t'(1) << f1);
        end
        if (f2 != no_flip) begin
            rx = rx ^ (secded_pkg::code_t'(1) << f2);
        end
        return rx;
    endfunction

    function automatic expect_t expect_for(input secded_pkg::data_t data,
                                           input int f1, input int f2);
        expect_t            e;
        secded_pkg::code_t  rx;
        int                 flips;
        e.code = encode_word(data);
        rx     = flip_bits(e.code, f1, f2);
        flips  = 0;
        if (f1 != no_flip) begin
            flips++;
        end
        if (f2 != no_flip) begin
            flips++;
        end
        e.single_err = (flips == 1);
        e.double_err = (flips == 2);
        e.data = (flips == 2) ? rx[secded_pkg::data_width-1:0] : data;  // no repair.
        return e;
    endfunction

    // ------------------------------------------------------------------------
    // table setup
    // ------------------------------------------------------------------------
    function automatic secded_pkg::data_t random_data();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic int random_pos();
        return int'($unsigned($random(seed)) % secded_pkg::code_width);
    endfunction

    task automatic set_entry(input int n, input string name, input secded_pkg::data_t data,
                             input int f1, input int f2);
        tbl_name[n]  = name;
        tbl_data[n]  = data;
        tbl_flip1[n] = f1;
        tbl_flip2[n] = f2;
    endtask

    task automatic build_table();
        int n;
        int p;
        int q;
        n = 0;
        set_entry(n, "zero", '0, no_flip, no_flip);
        n++;
        set_entry(n, "ones", '1, no_flip, no_flip);
        n++;
        for (int i = 0; i < num_walk; i++) begin
            set_entry(n, $sformatf("walk1_%0d", i), secded_pkg::data_t'(1) << i,
                      no_flip, no_flip);
            n++;
        end
        for (int i = 0; i < num_single; i++) begin
            set_entry(n, $sformatf("single_%0d", i), random_data(), i, no_flip);
            n++;
        end
        for (int i = 0; i < num_double; i++) begin
            set_entry(n, $sformatf("double_%0d", i), random_data(), 3 * i,
                      secded_pkg::code_width - 1 - 2 * i);
            n++;
        end
        // error kinds rotate every cycle.
        for (int i = 0; i < num_mixed; i++) begin
            p = random_pos();
            q = (p + 1 + random_pos() % (secded_pkg::code_width - 1)) % secded_pkg::code_width;
            case (i % 3)
                0: set_entry(n, $sformatf("mixed_%0d", i), random_data(), no_flip, no_flip);
                1: set_entry(n, $sformatf("mixed_%0d", i), random_data(), p, no_flip);
                default: set_entry(n, $sformatf("mixed_%0d", i), random_data(), p, q);
            endcase
            n++;
        end
    endtask

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input string sig,
                               input secded_pkg::code_t exp, input secded_pkg::code_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAIL %s %s expected %h actual %h", name, sig, exp, act);
        end
    endtask

    task automatic compare_outputs(input string name, input expect_t e);
        check_value(name, "code_out", e.code, code_out);
        check_value(name, "data_out", 72'(e.data), 72'(data_out));
        check_value(name, "single_err", 72'(e.single_err), 72'(single_err));
        check_value(name, "double_err", 72'(e.double_err), 72'(double_err));
    endtask

    initial begin
        int idx;
        clk     = 1'b0;
        rst_n   = 1'b0;
        data_in = '0;
        code_in = '0;
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        compare_outputs("reset", '0);  // pipelines still hold zeros.
        for (int t = 0; t < num_entries + 3; t++) begin
            @(negedge clk);
            if (t >= 3) begin
                idx = idx_q.pop_front();
                compare_outputs(tbl_name[idx], exp_q.pop_front());
            end
            if (t < num_entries) begin
                data_in = tbl_data[t];
                code_in = flip_bits(encode_word(tbl_data[t]), tbl_flip1[t], tbl_flip2[t]);
                exp_q.push_back(expect_for(tbl_data[t], tbl_flip1[t], tbl_flip2[t]));
                idx_q.push_back(t);
            end
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // ends a stuck run after the table plus some margin.
    initial begin
        #((num_entries + 20) * clk_period);
        $display("timeout after %0d clock periods, the test sequence did not complete",
                 num_entries + 20);
        $display("Verification failed");
        $finish;
    end

endmodule

/* secded_codec_top.sv */
// secded codec top: independent three stage encoder and decoder paths for 64-bit words.
`timescale 1ns/10ps

module secded_codec_top (
    input  logic               clk,
    input  logic               rst_n,
    // encoder path.
    input  secded_pkg::data_t  data_in,
    output secded_pkg::code_t  code_out,
    // decoder path.
    input  secded_pkg::code_t  code_in,
    output secded_pkg::data_t  data_out,
    output logic               single_err,
    output logic               double_err
);

    secded_pkg::code_t      code_d;
    secded_pkg::syndrome_t  syndrome;
    logic                   parity_err;

    // ------------------------------------------------------------------------
    // encoder
    // ------------------------------------------------------------------------
    secded_hamming_gen u_hamming_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .data_in  (data_in),
        .code_out (code_out)
    );

    // ------------------------------------------------------------------------
    // decoder, stages 1-2 then stage 3.
    // ------------------------------------------------------------------------
    secded_syndrome_calc u_syndrome_calc (
        .clk        (clk),
        .rst_n      (rst_n),
        .code_in    (code_in),
        .code_d     (code_d),
        .syndrome   (syndrome),
        .parity_err (parity_err)
    );

    secded_corrector u_corrector (
        .clk        (clk),
        .rst_n      (rst_n),
        .code_d     (code_d),
        .syndrome   (syndrome),
        .parity_err (parity_err),
        .data_out   (data_out),
        .single_err (single_err),
        .double_err (double_err)
    );

endmodule

/* secded_corrector.sv */
// secded decoder back end: classifies the error, flips a faulty data bit and registers the result.
`timescale 1ns/10ps

module secded_corrector (
    input  logic                   clk,
    input  logic                   rst_n,
    input  secded_pkg::code_t      code_d,
    input  secded_pkg::syndrome_t  syndrome,
    input  logic                   parity_err,
    output secded_pkg::data_t      data_out,
    output logic                   single_err,
    output logic                   double_err
);

    secded_pkg::data_t  flip_mask;
    secded_pkg::data_t  data_fix;
    logic               dbl_next;

    // one hot on the data bit that sits at the syndrome position.
    // zero syndrome and check positions leave the mask empty.
    always_comb begin
        for (int i = 0; i < secded_pkg::data_width; i++) begin
            flip_mask[i] = (secded_pkg::data_pos(i) == syndrome);
        end
    end

    // ------------------------------------------------------------------------
    // classification
    // ------------------------------------------------------------------------
    // odd overall parity means one bit went bad, so correct it.
    assign data_fix = parity_err ? (code_d[secded_pkg::data_width-1:0] ^ flip_mask)
                                 : code_d[secded_pkg::data_width-1:0];

    // even parity with a nonzero syndrome cannot be a single error.
    assign dbl_next = !parity_err && (syndrome != '0);

    // ------------------------------------------------------------------------
    // stage 3: output register.
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out   <= '0;
            single_err <= 1'b0;
            double_err <= 1'b0;
        end else begin
            data_out   <= data_fix;
            single_err <= parity_err;
            double_err <= dbl_next;
        end
    end

endmodule

/* secded_syndrome_calc.sv */
// secded decoder front end: registers the code word, then forms syndrome and parity mismatch.
`timescale 1ns/10ps

module secded_syndrome_calc (
    input  logic                   clk,
    input  logic                   rst_n,
    input  secded_pkg::code_t      code_in,
    output secded_pkg::code_t      code_d,
    output secded_pkg::syndrome_t  syndrome,
    output logic                   parity_err
);

    localparam int ham_width = secded_pkg::check_width - 1;

    secded_pkg::code_t      code_s1;
    secded_pkg::syndrome_t  ham_calc;
    secded_pkg::syndrome_t  syn_next;

    // ------------------------------------------------------------------------
    // stage 1: input register.
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            code_s1 <= '0;
        end else begin
            code_s1 <= code_in;
        end
    end

    // recompute the hamming checks from the received data bits.
    always_comb begin
        secded_pkg::syndrome_t pos;
        ham_calc = '0;
        for (int i = 0; i < secded_pkg::data_width; i++) begin
            pos = secded_pkg::data_pos(i);
            for (int k = 0; k < ham_width; k++) begin
                if (pos[k]) begin
                    ham_calc[k] = ham_calc[k] ^ code_s1[i];
                end
            end
        end
    end

    // mismatch against the received check bits.
    assign syn_next = ham_calc ^ code_s1[secded_pkg::data_width +: ham_width];

    // ------------------------------------------------------------------------
    // stage 2: syndrome, overall parity and the delayed word.
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            code_d     <= '0;
            syndrome   <= '0;
            parity_err <= 1'b0;
        end else begin
            code_d     <= code_s1;
            syndrome   <= syn_next;
            parity_err <= ^code_s1;  // even over all 72 bits when intact.
        end
    end

endmodule

/* secded_hamming_gen.sv */
// secded encoder: three stage pipeline turning a 64-bit data word into a 72-bit code word.
`timescale 1ns/10ps

module secded_hamming_gen (
    input  logic               clk,
    input  logic               rst_n,
    input  secded_pkg::data_t  data_in,
    output secded_pkg::code_t  code_out
);

    localparam int ham_width = secded_pkg::check_width - 1;

    secded_pkg::data_t       data_s1;
    secded_pkg::data_t       data_s2;
    logic [ham_width-1:0]    ham_s2;
    logic [ham_width-1:0]    ham_calc;
    secded_pkg::check_t      check_full;

    // ------------------------------------------------------------------------
    // stage 1: capture the data word.
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_s1 <= '0;
        end else begin
            data_s1 <= data_in;
        end
    end

    // hamming checks, bit k covers every data bit whose position has bit k set.
    always_comb begin
        secded_pkg::syndrome_t pos;
        ham_calc = '0;
        for (int i = 0; i < secded_pkg::data_width; i++) begin
            pos = secded_pkg::data_pos(i);
            for (int k = 0; k < ham_width; k++) begin
                if (pos[k]) begin
                    ham_calc[k] = ham_calc[k] ^ data_s1[i];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // stage 2: check bits 0..6, data carried along in the same stage.
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_s2 <= '0;
            ham_s2  <= '0;
        end else begin
            data_s2 <= data_s1;
            ham_s2  <= ham_calc;
        end
    end

    // overall parity over the aligned data and hamming bits.
    assign check_full = {^{data_s2, ham_s2}, ham_s2};

    // ------------------------------------------------------------------------
    // stage 3: code word register.
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            code_out <= '0;
        end else begin
            code_out <= {check_full, data_s2};  // check bits on top.
        end
    end

endmodule

/* secded_pkg.sv */
// secded package: code word widths, vector types and the data bit position map.

package secded_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int data_width  = 64;
    localparam int check_width = 8;                       // 7 hamming + overall.
    localparam int code_width  = data_width + check_width;

    typedef logic [data_width-1:0]    data_t;
    typedef logic [check_width-1:0]   check_t;
    typedef logic [code_width-1:0]    code_t;
    typedef logic [check_width-2:0]   syndrome_t;         // error position or zero.

    // ------------------------------------------------------------------------
    // data bit i lives at the (i+1)-th position that is not a power of two.
    // positions 1, 2, 4 .. 64 belong to the hamming check bits.
    // ------------------------------------------------------------------------
    function automatic syndrome_t data_pos(input int i);
        int pos;
        int cnt;
        pos = 0;
        cnt = 0;
        for (int p = 1; p < code_width; p++) begin
            if ((p & (p - 1)) != 0) begin  // skip powers of two.
                if (cnt == i) begin
                    pos = p;
                end
                cnt++;
            end
        end
        return syndrome_t'(pos);
    endfunction

endpackage
